// File: Bender.yml
package:
  name: attn_mem_top

sources:
  - files:
      - design/attn_mem_pkg.sv
      - design/vector_buffer.sv
      - design/fused_mac_engine.sv
      - design/memory_controller.sv
      - design/attn_mem_top.sv
  - target: test
    files:
      - verif/mem_model.sv
      - verif/tb_attn_mem_top.sv

// File: attn_mem_top.f
design/attn_mem_pkg.sv
design/vector_buffer.sv
design/fused_mac_engine.sv
design/memory_controller.sv
design/attn_mem_top.sv
verif/mem_model.sv
verif/tb_attn_mem_top.sv

// File: design/attn_mem_pkg.sv
package attn_mem_pkg;

    // ------------------------------
    // Sizing
    // ------------------------------
    localparam int LANES          = 8;   // Lanes per vector
    localparam int LANE_W         = 16;  // Bits per lane
    localparam int BLOCKS_PER_VEC = 2;   // 64-bit memory beats per vector
    localparam int BLOCK_BYTES    = 8;   // Address step between beats
    localparam int MAX_SEQ_LEN    = 16;  // Buffer depth and index range

    // ------------------------------
    // Memory port types
    // ------------------------------
    typedef logic [31:0] addr_t;       // Byte address
    typedef logic [63:0] mem_block_t;  // One memory beat
    typedef logic [3:0]  mem_tag_t;    // Zero means no transaction

    typedef enum logic [1:0] {
        MEM_NONE,
        MEM_LOAD,
        MEM_STORE
    } mem_cmd_e;

    // Controller toward memory
    typedef struct packed {
        mem_cmd_e   cmd;
        addr_t      addr;
        mem_block_t data;   // Store data, ignored on loads
    } mem_req_t;

    // Memory toward controller
    typedef struct packed {
        mem_tag_t   accept_tag;  // Same-cycle answer to a command, zero if refused
        mem_block_t data;        // Load return data
        mem_tag_t   data_tag;    // Tag of the load the data belongs to
    } mem_rsp_t;

    // ------------------------------
    // Vector types
    // ------------------------------
    typedef logic [LANE_W-1:0] lane_t;

    // Lane 0 sits in the low bits, so block 0 carries lanes 0..3
    typedef struct packed {
        lane_t [LANES-1:0] lane;
    } q_vector_t;

    typedef struct packed {
        lane_t [LANES-1:0] lane;
    } k_vector_t;

    typedef struct packed {
        lane_t [LANES-1:0] lane;
    } v_vector_t;

    typedef struct packed {
        lane_t [LANES-1:0] lane;
    } o_vector_t;

endpackage

// File: design/attn_mem_top.sv
module attn_mem_top #(
    parameter int                  SEQ_LEN = attn_mem_pkg::MAX_SEQ_LEN,
    parameter attn_mem_pkg::addr_t K_BASE  = 32'h0000_1000,
    parameter attn_mem_pkg::addr_t V_BASE  = 32'h0000_2000,
    parameter attn_mem_pkg::addr_t Q_BASE  = 32'h0000_3000,
    parameter attn_mem_pkg::addr_t O_BASE  = 32'h0000_4000
)(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start,
    output logic                   done,
    output attn_mem_pkg::mem_req_t mem_req,
    input  attn_mem_pkg::mem_rsp_t mem_rsp
);

    // Controller to buffers
    logic                    k_ld_vld, k_ld_rdy;
    logic                    v_ld_vld, v_ld_rdy;
    logic                    q_ld_vld, q_ld_rdy;
    attn_mem_pkg::k_vector_t k_ld_vec;
    attn_mem_pkg::v_vector_t v_ld_vec;
    attn_mem_pkg::q_vector_t q_ld_vec;

    // Buffers to engine
    logic                    k_op_vld, k_op_rdy;
    logic                    v_op_vld, v_op_rdy;
    logic                    q_op_vld, q_op_rdy;
    attn_mem_pkg::k_vector_t k_op_vec;
    attn_mem_pkg::v_vector_t v_op_vec;
    attn_mem_pkg::q_vector_t q_op_vec;

    // Engine to O buffer, O buffer back to controller
    logic                    o_res_vld, o_res_rdy;
    logic                    o_dr_vld, o_dr_rdy;
    attn_mem_pkg::o_vector_t o_res_vec;
    attn_mem_pkg::o_vector_t o_dr_vec;

    // ------------------------------
    // Producer
    // ------------------------------
    memory_controller #(
        .SEQ_LEN (SEQ_LEN), .K_BASE (K_BASE), .V_BASE (V_BASE),
        .Q_BASE  (Q_BASE),  .O_BASE (O_BASE)
    ) u_ctrl (
        .clk   (clk),      .rst_n (rst_n),    .start (start),    .done  (done),
        .mem_req (mem_req), .mem_rsp (mem_rsp),
        .k_vld (k_ld_vld), .k_rdy (k_ld_rdy), .k_vec (k_ld_vec),
        .v_vld (v_ld_vld), .v_rdy (v_ld_rdy), .v_vec (v_ld_vec),
        .q_vld (q_ld_vld), .q_rdy (q_ld_rdy), .q_vec (q_ld_vec),
        .o_vld (o_dr_vld), .o_rdy (o_dr_rdy), .o_vec (o_dr_vec)
    );

    // ------------------------------
    // Vector buffers
    // ------------------------------
    vector_buffer #(.vec_t (attn_mem_pkg::k_vector_t), .DEPTH (attn_mem_pkg::MAX_SEQ_LEN))
    u_k_buf (
        .clk (clk), .rst_n (rst_n),
        .in_vld  (k_ld_vld), .in_rdy  (k_ld_rdy), .in_vec  (k_ld_vec),
        .out_vld (k_op_vld), .out_rdy (k_op_rdy), .out_vec (k_op_vec)
    );

    vector_buffer #(.vec_t (attn_mem_pkg::v_vector_t), .DEPTH (attn_mem_pkg::MAX_SEQ_LEN))
    u_v_buf (
        .clk (clk), .rst_n (rst_n),
        .in_vld  (v_ld_vld), .in_rdy  (v_ld_rdy), .in_vec  (v_ld_vec),
        .out_vld (v_op_vld), .out_rdy (v_op_rdy), .out_vec (v_op_vec)
    );

    vector_buffer #(.vec_t (attn_mem_pkg::q_vector_t), .DEPTH (attn_mem_pkg::MAX_SEQ_LEN))
    u_q_buf (
        .clk (clk), .rst_n (rst_n),
        .in_vld  (q_ld_vld), .in_rdy  (q_ld_rdy), .in_vec  (q_ld_vec),
        .out_vld (q_op_vld), .out_rdy (q_op_rdy), .out_vec (q_op_vec)
    );

    // Results wait here until the drain phase
    vector_buffer #(.vec_t (attn_mem_pkg::o_vector_t), .DEPTH (attn_mem_pkg::MAX_SEQ_LEN))
    u_o_buf (
        .clk (clk), .rst_n (rst_n),
        .in_vld  (o_res_vld), .in_rdy  (o_res_rdy), .in_vec  (o_res_vec),
        .out_vld (o_dr_vld),  .out_rdy (o_dr_rdy),  .out_vec (o_dr_vec)
    );

    // Consumer
    fused_mac_engine u_engine (
        .clk   (clk),       .rst_n (rst_n),
        .q_vld (q_op_vld),  .q_rdy (q_op_rdy),  .q_vec (q_op_vec),
        .k_vld (k_op_vld),  .k_rdy (k_op_rdy),  .k_vec (k_op_vec),
        .v_vld (v_op_vld),  .v_rdy (v_op_rdy),  .v_vec (v_op_vec),
        .o_vld (o_res_vld), .o_rdy (o_res_rdy), .o_vec (o_res_vec)
    );

endmodule

// File: design/fused_mac_engine.sv
module fused_mac_engine (
    input  logic                    clk,
    input  logic                    rst_n,

    // Q stream
    input  logic                    q_vld,
    output logic                    q_rdy,
    input  attn_mem_pkg::q_vector_t q_vec,

    // K stream
    input  logic                    k_vld,
    output logic                    k_rdy,
    input  attn_mem_pkg::k_vector_t k_vec,

    // V stream
    input  logic                    v_vld,
    output logic                    v_rdy,
    input  attn_mem_pkg::v_vector_t v_vec,

    // Registered O stream
    output logic                    o_vld,
    input  logic                    o_rdy,
    output attn_mem_pkg::o_vector_t o_vec
);

    logic                    all_vld;   // All three operands present
    logic                    slot_free; // Output register empty or emptying now
    logic                    fire;      // Joined pop of Q, K and V
    attn_mem_pkg::o_vector_t o_next;

    assign all_vld   = q_vld && k_vld && v_vld;
    assign slot_free = !o_vld || o_rdy;
    assign fire      = all_vld && slot_free;

    // Readies move as one
    assign q_rdy = fire;
    assign k_rdy = fire;
    assign v_rdy = fire;

    // ------------------------------
    // Lane-wise Q * K + V
    // ------------------------------
    always_comb begin
        for (int i = 0; i < attn_mem_pkg::LANES; i++) begin
            // Evaluated at lane width so upper product bits drop out
            o_next.lane[i] = attn_mem_pkg::lane_t'(q_vec.lane[i] * k_vec.lane[i]
                                                   + v_vec.lane[i]);
        end
    end

    // Output valid
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_vld <= 1'b0;
        end else if (fire) begin
            o_vld <= 1'b1;             // Back-to-back when the slot hands over
        end else if (o_rdy) begin
            o_vld <= 1'b0;
        end
    end

    // Result register
    always_ff @(posedge clk) begin
        if (fire) o_vec <= o_next;
    end

endmodule

// File: design/memory_controller.sv
module memory_controller #(
    parameter int                  SEQ_LEN = attn_mem_pkg::MAX_SEQ_LEN,
    parameter attn_mem_pkg::addr_t K_BASE  = 32'h0000_1000,
    parameter attn_mem_pkg::addr_t V_BASE  = 32'h0000_2000,
    parameter attn_mem_pkg::addr_t Q_BASE  = 32'h0000_3000,
    parameter attn_mem_pkg::addr_t O_BASE  = 32'h0000_4000
)(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start,
    output logic                    done,

    // Tagged memory port
    output attn_mem_pkg::mem_req_t  mem_req,
    input  attn_mem_pkg::mem_rsp_t  mem_rsp,

    // Loads toward the K, V and Q buffers
    output logic                    k_vld,
    input  logic                    k_rdy,
    output attn_mem_pkg::k_vector_t k_vec,
    output logic                    v_vld,
    input  logic                    v_rdy,
    output attn_mem_pkg::v_vector_t v_vec,
    output logic                    q_vld,
    input  logic                    q_rdy,
    output attn_mem_pkg::q_vector_t q_vec,

    // Drain from the O buffer
    input  logic                    o_vld,
    output logic                    o_rdy,
    input  attn_mem_pkg::o_vector_t o_vec
);

    localparam int IDX_W = $clog2(attn_mem_pkg::MAX_SEQ_LEN);
    localparam int BLK_W = (attn_mem_pkg::BLOCKS_PER_VEC > 1) ?
                           $clog2(attn_mem_pkg::BLOCKS_PER_VEC) : 1;

    typedef enum logic [2:0] {
        PH_IDLE,
        PH_LOAD_K,
        PH_LOAD_V,
        PH_LOAD_Q,
        PH_DRAIN_O,
        PH_DONE
    } phase_e;

    typedef enum logic [1:0] {
        M_IDLE,
        M_READ,
        M_WRITE
    } mstate_e;

    phase_e  phase, next_phase;
    mstate_e mem_state, next_mem_state;

    logic [IDX_W-1:0]       vec_index;      // Vector within the phase
    logic [BLK_W-1:0]       blk_count;      // Block within the vector
    logic                   have_full_vec;  // vec_buf holds a whole vector
    logic                   load_pending;   // One load in flight
    attn_mem_pkg::mem_tag_t load_tag;       // Its accept tag
    attn_mem_pkg::mem_block_t [attn_mem_pkg::BLOCKS_PER_VEC-1:0] vec_buf;

    logic                load_phase;
    logic                last_vec;
    logic                last_blk;
    logic                buf_rdy;     // Ready of the buffer the phase feeds
    logic                vec_taken;   // Loaded vector handed over
    logic                o_taken;     // O vector popped for drain
    logic                load_acc;
    logic                load_ret;
    logic                store_acc;
    attn_mem_pkg::addr_t base;

    assign load_phase = (phase == PH_LOAD_K) || (phase == PH_LOAD_V) || (phase == PH_LOAD_Q);
    assign last_vec   = (vec_index == IDX_W'(SEQ_LEN - 1));
    assign last_blk   = (blk_count == BLK_W'(attn_mem_pkg::BLOCKS_PER_VEC - 1));
    assign done       = (phase == PH_DONE);   // One cycle, then back to idle

    // ------------------------------
    // Buffer handshakes
    // ------------------------------
    assign k_vld = have_full_vec && (phase == PH_LOAD_K);
    assign v_vld = have_full_vec && (phase == PH_LOAD_V);
    assign q_vld = have_full_vec && (phase == PH_LOAD_Q);
    assign k_vec = attn_mem_pkg::k_vector_t'(vec_buf);
    assign v_vec = attn_mem_pkg::v_vector_t'(vec_buf);
    assign q_vec = attn_mem_pkg::q_vector_t'(vec_buf);

    always_comb begin
        unique case (phase)
            PH_LOAD_K: buf_rdy = k_rdy;
            PH_LOAD_V: buf_rdy = v_rdy;
            PH_LOAD_Q: buf_rdy = q_rdy;
            default:   buf_rdy = 1'b0;
        endcase
    end

    assign vec_taken = load_phase && have_full_vec && buf_rdy;
    assign o_rdy     = (phase == PH_DRAIN_O) && !have_full_vec;  // Empty staging only
    assign o_taken   = o_vld && o_rdy;

    // ------------------------------
    // Memory request
    // ------------------------------
    always_comb begin
        unique case (phase)
            PH_LOAD_K: base = K_BASE;
            PH_LOAD_V: base = V_BASE;
            PH_LOAD_Q: base = Q_BASE;
            default:   base = O_BASE;
        endcase
    end

    always_comb begin
        mem_req.cmd  = attn_mem_pkg::MEM_NONE;
        // Block index is i * BLOCKS_PER_VEC + b, stepped by BLOCK_BYTES
        mem_req.addr = base + attn_mem_pkg::addr_t'(
                       (vec_index * attn_mem_pkg::BLOCKS_PER_VEC + blk_count)
                       * attn_mem_pkg::BLOCK_BYTES);
        mem_req.data = vec_buf[blk_count];
        if (mem_state == M_READ && !load_pending) mem_req.cmd = attn_mem_pkg::MEM_LOAD;
        else if (mem_state == M_WRITE) mem_req.cmd = attn_mem_pkg::MEM_STORE;
    end

    assign load_acc  = (mem_req.cmd == attn_mem_pkg::MEM_LOAD) && (mem_rsp.accept_tag != '0);
    assign store_acc = (mem_req.cmd == attn_mem_pkg::MEM_STORE) && (mem_rsp.accept_tag != '0);
    assign load_ret  = load_pending && (mem_rsp.data_tag == load_tag);  // Latency ends here

    // Phase sequencing
    always_comb begin
        next_phase = phase;
        unique case (phase)
            PH_IDLE:    if (start) next_phase = PH_LOAD_K;
            PH_LOAD_K:  if (vec_taken && last_vec) next_phase = PH_LOAD_V;
            PH_LOAD_V:  if (vec_taken && last_vec) next_phase = PH_LOAD_Q;
            PH_LOAD_Q:  if (vec_taken && last_vec) next_phase = PH_DRAIN_O;
            PH_DRAIN_O: if (store_acc && last_blk && last_vec) next_phase = PH_DONE;
            default:    next_phase = PH_IDLE;   // PH_DONE
        endcase
    end

    // Request sequencing
    always_comb begin
        next_mem_state = mem_state;
        unique case (mem_state)
            M_IDLE: begin
                if (load_phase && !have_full_vec) next_mem_state = M_READ;
                else if (phase == PH_DRAIN_O && have_full_vec) next_mem_state = M_WRITE;
            end
            M_READ:  if (load_ret && last_blk) next_mem_state = M_IDLE;   // Vector assembled
            M_WRITE: if (store_acc && last_blk) next_mem_state = M_IDLE;  // Vector written
            default: next_mem_state = M_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase         <= PH_IDLE;
            mem_state     <= M_IDLE;
            vec_index     <= '0;
            blk_count     <= '0;
            have_full_vec <= 1'b0;
            load_pending  <= 1'b0;
            load_tag      <= '0;
        end else begin
            phase     <= next_phase;
            mem_state <= next_mem_state;
            if (load_acc) begin
                load_pending <= 1'b1;
                load_tag     <= mem_rsp.accept_tag;
            end
            if (load_ret) begin
                load_pending <= 1'b0;
                blk_count    <= last_blk ? '0 : blk_count + 1'b1;
                if (last_blk) have_full_vec <= 1'b1;
            end
            if (vec_taken) begin
                have_full_vec <= 1'b0;
                vec_index     <= last_vec ? '0 : vec_index + 1'b1;  // Zero for next phase
            end
            if (o_taken) have_full_vec <= 1'b1;
            if (store_acc) begin
                blk_count <= last_blk ? '0 : blk_count + 1'b1;
                if (last_blk) begin
                    have_full_vec <= 1'b0;
                    vec_index     <= last_vec ? '0 : vec_index + 1'b1;
                end
            end
        end
    end

    // Staging register, filled block by block or whole from O
    always_ff @(posedge clk) begin
        if (load_ret) vec_buf[blk_count] <= mem_rsp.data;
        else if (o_taken) vec_buf <= o_vec;
    end

    // ------------------------------
    // Checks
    // ------------------------------
    // Port stays quiet from acceptance of a load until its tag returns
    a_one_load: assert property (@(posedge clk) disable iff (!rst_n)
        load_acc |=> (mem_req.cmd == attn_mem_pkg::MEM_NONE) until load_ret);

    // Refused request comes back unchanged
    a_retry_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_req.cmd != attn_mem_pkg::MEM_NONE) && (mem_rsp.accept_tag == '0)
        |=> $stable(mem_req));

    a_index_range: assert property (@(posedge clk) disable iff (!rst_n)
        vec_index <= IDX_W'(SEQ_LEN - 1));

endmodule

// File: design/vector_buffer.sv
module vector_buffer #(
    parameter type vec_t = attn_mem_pkg::q_vector_t,       // Payload carried per entry
    parameter int  DEPTH = attn_mem_pkg::MAX_SEQ_LEN       // Whole sequence fits
)(
    input  logic clk,
    input  logic rst_n,

    // Write side
    input  logic in_vld,
    output logic in_rdy,
    input  vec_t in_vec,

    // Read side
    output logic out_vld,
    input  logic out_rdy,
    output vec_t out_vec
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    vec_t             mem [DEPTH];   // Storage
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;         // Occupancy from 0 to DEPTH

    logic full;
    logic empty;
    logic push;
    logic pop;

    assign full    = (count == (PTR_W+1)'(DEPTH));
    assign empty   = (count == '0);
    assign in_rdy  = !full;
    assign out_vld = !empty;
    assign out_vec = mem[rd_ptr];    // Head of queue when out_vld is high
    assign push    = in_vld && in_rdy;
    assign pop     = out_vld && out_rdy;

    // ------------------------------
    // Pointers and count
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;  // Wrap
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) count <= count + 1'b1;
            else if (pop && !push) count <= count - 1'b1;
        end
    end

    // Write port
    always_ff @(posedge clk) begin
        if (push) mem[wr_ptr] <= in_vec;
    end

    // Occupancy never runs past the depth
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        count <= (PTR_W+1)'(DEPTH));

    // Empty buffer has its read side level with the write side
    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
        empty |-> (wr_ptr == rd_ptr));

endmodule

// File: verif/mem_model.sv
module mem_model #(
    parameter int          WORDS = 4096,          // 64-bit words, 32 KiB of address space
    parameter logic [31:0] SEED  = 32'hdc0d1886
)(
    input  logic                   clk,
    input  logic                   rst_n,
    input  int                     refuse_pct,    // Percent of commands refused
    input  int                     max_lat,       // Load latency drawn from 1..max_lat
    input  attn_mem_pkg::mem_req_t mem_req,
    output attn_mem_pkg::mem_rsp_t mem_rsp
);
    timeunit 1ns;
    timeprecision 100ps;

    typedef struct packed {
        attn_mem_pkg::mem_tag_t   tag;
        attn_mem_pkg::mem_block_t data;
        logic [31:0]              due;    // Cycle the data goes out
    } pend_t;

    attn_mem_pkg::mem_block_t words [WORDS];
    pend_t                    pend_q [$];    // Loads in flight, oldest first
    logic [31:0]              rnd_state;
    logic [31:0]              cycle;
    logic                     accept_ok;     // Answer prepared for this cycle
    attn_mem_pkg::mem_tag_t   next_tag;      // Cycles 1..15, zero is never handed out
    attn_mem_pkg::mem_tag_t   ret_tag;
    attn_mem_pkg::mem_block_t ret_data;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    // Same-cycle accept tag, zero when refused
    assign mem_rsp = '{
        accept_tag: (mem_req.cmd != attn_mem_pkg::MEM_NONE && accept_ok) ? next_tag : '0,
        data:       ret_data,
        data_tag:   ret_tag
    };

    // Each word starts as a pattern of its own byte address
    initial begin
        for (int i = 0; i < WORDS; i++) begin
            words[i] = {~32'(i * 8), 32'(i * 8)};
        end
    end

    // ------------------------------
    // Acceptance and load return
    // ------------------------------
    always @(posedge clk or negedge rst_n) begin
        pend_t       p;
        logic [31:0] idx;
        if (!rst_n) begin
            rnd_state = SEED;
            cycle     = '0;
            pend_q.delete();
            accept_ok <= 1'b0;
            next_tag  <= 4'd1;
            ret_tag   <= '0;
            ret_data  <= '0;
        end else begin
            cycle = cycle + 1;
            if (pend_q.size() > 0 && pend_q[0].due <= cycle) begin
                ret_tag  <= pend_q[0].tag;     // Shown for one cycle only
                ret_data <= pend_q[0].data;
                void'(pend_q.pop_front());
            end else begin
                ret_tag  <= '0;
            end
            if (mem_rsp.accept_tag != '0) begin
                idx = (mem_req.addr >> 3) % WORDS;
                if (mem_req.cmd == attn_mem_pkg::MEM_STORE) begin
                    words[idx] = mem_req.data;   // Store done on acceptance
                end else begin
                    rnd_state = xorshift32(rnd_state);
                    p.tag     = mem_rsp.accept_tag;
                    p.data    = words[idx];
                    p.due     = cycle + 1 + (rnd_state % max_lat);
                    pend_q.push_back(p);
                end
                next_tag <= (next_tag == 4'hf) ? 4'h1 : next_tag + 4'h1;
            end
            rnd_state = xorshift32(rnd_state);
            accept_ok <= (rnd_state % 100) >= refuse_pct;   // Decision for next cycle
        end
    end

    // Backdoor access
    task automatic write_block(input attn_mem_pkg::addr_t addr,
                               input attn_mem_pkg::mem_block_t data);
        words[(addr >> 3) % WORDS] = data;
    endtask

    task automatic read_block(input attn_mem_pkg::addr_t addr,
                              output attn_mem_pkg::mem_block_t data);
        data = words[(addr >> 3) % WORDS];
    endtask

endmodule

// File: verif/tb_attn_mem_top.sv
module tb_attn_mem_top;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int                  SEQ_LEN = 12;
    localparam attn_mem_pkg::addr_t K_BASE  = 32'h0000_1000;
    localparam attn_mem_pkg::addr_t V_BASE  = 32'h0000_2000;
    localparam attn_mem_pkg::addr_t Q_BASE  = 32'h0000_3000;
    localparam attn_mem_pkg::addr_t O_BASE  = 32'h0000_4000;
    localparam int BPV         = attn_mem_pkg::BLOCKS_PER_VEC;
    localparam int BLK_BYTES   = attn_mem_pkg::BLOCK_BYTES;
    localparam int REGION_BLKS = SEQ_LEN * BPV;                     // Blocks per region
    localparam int LANES_BLK   = attn_mem_pkg::LANES / BPV;         // Lanes per block
    localparam int RUNS        = 4;
    localparam int MAX_LAT     = 12;                                // Longest latency used
    localparam int CYCLE_LIMIT = RUNS * SEQ_LEN * BPV * 4 * (MAX_LAT + 4);

    logic                   clk;
    logic                   rst_n;
    logic                   start;
    logic                   done;
    attn_mem_pkg::mem_req_t mem_req;
    attn_mem_pkg::mem_rsp_t mem_rsp;
    int                     refuse_pct;
    int                     max_lat;

    attn_mem_pkg::mem_block_t k_data [REGION_BLKS];   // Shadow of preloaded regions
    attn_mem_pkg::mem_block_t v_data [REGION_BLKS];
    attn_mem_pkg::mem_block_t q_data [REGION_BLKS];
    logic [31:0]              rnd_state;
    int                       cycles;
    int                       load_count;     // Accepted loads in this run
    int                       store_count;    // Accepted stores in this run
    int                       refusals;
    int                       done_count;
    logic                     refused_prev;
    attn_mem_pkg::mem_req_t   held_req;

    attn_mem_top #(
        .SEQ_LEN (SEQ_LEN), .K_BASE (K_BASE), .V_BASE (V_BASE),
        .Q_BASE  (Q_BASE),  .O_BASE (O_BASE)
    ) u_dut (
        .clk (clk), .rst_n (rst_n), .start (start), .done (done),
        .mem_req (mem_req), .mem_rsp (mem_rsp)
    );

    mem_model #(.SEED (32'hdc0d1886)) u_mem (
        .clk (clk), .rst_n (rst_n), .refuse_pct (refuse_pct), .max_lat (max_lat),
        .mem_req (mem_req), .mem_rsp (mem_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ------------------------------
    // Helpers
    // ------------------------------
    task automatic end_with_failure();
        $display("*** FAILED ***");
        $fatal(1, "Simulation stopped at first failure");
    endtask

    task automatic check_eq(input logic [127:0] actual, input logic [127:0] expected,
                            input string what);
        if (actual !== expected) begin
            $display("[ERROR] %0t ns: %s: got 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
            end_with_failure();
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic attn_mem_pkg::mem_block_t random_block();
        attn_mem_pkg::mem_block_t blk;
        rnd_state  = xorshift32(rnd_state);
        blk[31:0]  = rnd_state;
        rnd_state  = xorshift32(rnd_state);
        blk[63:32] = rnd_state;
        return blk;
    endfunction

    // Address of the n-th load in K, V, Q order with each region ascending
    function automatic attn_mem_pkg::addr_t load_addr(input int n);
        attn_mem_pkg::addr_t base;
        if (n < REGION_BLKS) base = K_BASE;
        else if (n < 2 * REGION_BLKS) base = V_BASE;
        else if (n < 3 * REGION_BLKS) base = Q_BASE;
        else return 32'hffff_ffff;                     // One load too many
        return base + 32'((n % REGION_BLKS) * BLK_BYTES);
    endfunction

    function automatic logic in_o_region(input attn_mem_pkg::addr_t addr);
        return addr >= O_BASE && addr < O_BASE + 32'(REGION_BLKS * BLK_BYTES)
               && addr[2:0] == 3'd0;
    endfunction

    // Expected O block with lane l in bits 16l and up
    function automatic attn_mem_pkg::mem_block_t mac_block(input int b);
        attn_mem_pkg::mem_block_t res;
        logic [15:0] q;
        logic [15:0] k;
        logic [15:0] v;
        for (int l = 0; l < LANES_BLK; l++) begin
            q = q_data[b][16*l +: 16];
            k = k_data[b][16*l +: 16];
            v = v_data[b][16*l +: 16];
            res[16*l +: 16] = q * k + v;   // 16-bit context keeps the low bits
        end
        return res;
    endfunction

    // ------------------------------
    // Port monitor and cycle limit
    // ------------------------------
    always @(negedge clk) begin
        if (rst_n) begin
            if (refused_prev) check_eq(mem_req, held_req, "request changed while refused");
            if (mem_req.cmd != attn_mem_pkg::MEM_NONE && mem_rsp.accept_tag != '0) begin
                if (mem_req.cmd == attn_mem_pkg::MEM_LOAD) begin
                    check_eq(mem_req.addr, load_addr(load_count), "load address");
                    load_count = load_count + 1;
                end else begin
                    check_eq(load_count, 3 * REGION_BLKS, "loads finished before store");
                    check_eq(in_o_region(mem_req.addr), 1'b1, "store address in O region");
                    check_eq(store_count < REGION_BLKS, 1'b1, "store count in range");
                    store_count = store_count + 1;
                end
            end
            if (mem_req.cmd != attn_mem_pkg::MEM_NONE && mem_rsp.accept_tag == '0) begin
                refusals = refusals + 1;
            end
            if (done) done_count = done_count + 1;
            refused_prev = mem_req.cmd != attn_mem_pkg::MEM_NONE && mem_rsp.accept_tag == '0;
            held_req     = mem_req;
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: done not seen within %0d cycles", CYCLE_LIMIT);
            end_with_failure();
        end
    end

    // ------------------------------
    // Test steps
    // ------------------------------
    task automatic load_regions();
        for (int b = 0; b < REGION_BLKS; b++) begin
            k_data[b] = random_block();
            v_data[b] = random_block();
            q_data[b] = random_block();
            u_mem.write_block(K_BASE + 32'(b * BLK_BYTES), k_data[b]);
            u_mem.write_block(V_BASE + 32'(b * BLK_BYTES), v_data[b]);
            u_mem.write_block(Q_BASE + 32'(b * BLK_BYTES), q_data[b]);
        end
    endtask

    task automatic check_o_region();
        attn_mem_pkg::mem_block_t got;
        for (int b = 0; b < REGION_BLKS; b++) begin
            u_mem.read_block(O_BASE + 32'(b * BLK_BYTES), got);
            check_eq(got, mac_block(b), $sformatf("O block %0d", b));
        end
    endtask

    task automatic run_once(input int refuse, input int lat);
        int runs_before;
        runs_before = done_count;
        @(negedge clk);
        refuse_pct  = refuse;
        max_lat     = lat;
        load_count  = 0;
        store_count = 0;
        start       = 1'b1;
        @(negedge clk);
        start = 1'b0;
        while (!done) @(negedge clk);    // Hang ends at the cycle limit
        repeat (4) @(negedge clk);       // Idle tail where a second pulse would show
        check_eq(done_count, runs_before + 1, "done pulses in one run");
        check_eq(load_count, 3 * REGION_BLKS, "loads in one run");
        check_eq(store_count, REGION_BLKS, "stores in one run");
    endtask

    task automatic test_reset_quiet();
        for (int i = 0; i < 10; i++) begin
            @(negedge clk);
            check_eq(mem_req.cmd, attn_mem_pkg::MEM_NONE, "memory command in reset");
            check_eq(done, 1'b0, "done in reset");
        end
        rst_n = 1'b1;
        for (int i = 0; i < 5; i++) begin
            @(negedge clk);
            check_eq(mem_req.cmd, attn_mem_pkg::MEM_NONE, "memory command before start");
            check_eq(done, 1'b0, "done before start");
        end
    endtask

    task automatic test_full_run();
        load_regions();
        run_once(20, 4);
        check_o_region();
    endtask

    task automatic test_refusal_latency();
        int refused_before;
        refused_before = refusals;
        load_regions();
        run_once(60, MAX_LAT);               // Mostly refused with long latencies
        check_eq(refusals > refused_before, 1'b1, "refusals seen under stress");
        check_o_region();
    endtask

    task automatic test_repeat_start();
        for (int r = 0; r < 2; r++) begin
            load_regions();                   // Fresh data for each start
            run_once(30, 6);
            check_o_region();
        end
        check_eq(done, 1'b0, "done after last run");
    endtask

    initial begin
        rst_n        = 1'b0;
        start        = 1'b0;
        refuse_pct   = 0;
        max_lat      = 1;
        rnd_state    = 32'hdc0d1886;
        cycles       = 0;
        load_count   = 0;
        store_count  = 0;
        refusals     = 0;
        done_count   = 0;
        refused_prev = 1'b0;
        held_req     = '0;
        test_reset_quiet();
        test_full_run();
        test_refusal_latency();
        test_repeat_start();
        $display("*** PASSED ***");
        $finish;
    end

endmodule
